// ==== logic/ca_types_pkg.sv ====
// Data-path types for a fixed 4-lane, 40-bit build; change widths here only, no per-instance override
package ca_types_pkg;

  //////////////////////////////
  // Lane and FIFO geometry
  //////////////////////////////
  localparam int NUM_LANES        = 4;                // Lanes bonded into one beat
  localparam int BITS_PER_CHANNEL = 40;               // Marker bit plus payload
  localparam int AD_WIDTH         = 4;                // FIFO address bits
  localparam int FIFO_DEPTH       = 1 << AD_WIDTH;    // 16 entries per lane
  localparam int CNT_W            = AD_WIDTH + 1;     // Count must reach FIFO_DEPTH

  //////////////////////////////
  // Lane word and lane input
  //////////////////////////////
  typedef struct packed
  {
    logic                          marker;   // Alignment marker, MSB of the word
    logic [BITS_PER_CHANNEL-2:0]   payload;  // 39 data bits
  } lane_word_t;

  typedef struct packed
  {
    logic        valid;  // No back-pressure on this side
    lane_word_t  word;
  } lane_in_t;

  // Per-lane FIFO status
  typedef struct packed
  {
    logic full;      // Count at or above full_val
    logic pfull;     // Count at or above pfull_val
    logic empty;     // Count equal to empty_val
    logic pempty;    // Count at or below pempty_val
    logic overflow;  // One-cycle pulse, push dropped
  } lane_flags_t;

  // One word per lane, lane 0 in the low slot
  typedef lane_word_t [NUM_LANES-1:0] aligned_beat_t;

endpackage

// ==== logic/ca_regs_pkg.sv ====
// Register map for a 4-bit APB address space; unmapped addresses read zero and ignore writes
package ca_regs_pkg;

  //////////////////////////////
  // Register addresses
  //////////////////////////////
  localparam logic [3:0] ADDR_CTRL   = 4'h0;  // enable, soft_reset
  localparam logic [3:0] ADDR_THRESH = 4'h4;  // Flag thresholds
  localparam logic [3:0] ADDR_STATUS = 4'h8;  // State, sticky overflow
  localparam logic [3:0] ADDR_FLAGS  = 4'hC;  // Live lane flags, read only

  // Threshold fields, same widths as the register bit fields
  typedef struct packed
  {
    logic [5:0] full_val;
    logic [5:0] pfull_val;
    logic [2:0] empty_val;
    logic [2:0] pempty_val;
  } thresh_t;

  // Value after rst
  localparam thresh_t THRESH_RST = '{full_val: 6'd16, pfull_val: 6'd12,
                                     empty_val: 3'd0, pempty_val: 3'd2};

  // Alignment FSM, encoding is visible in STATUS[1:0]
  typedef enum logic [1:0]
  {
    ST_IDLE    = 2'd0,
    ST_HUNT    = 2'd1,
    ST_ALIGNED = 2'd2,
    ST_ERROR   = 2'd3
  } align_state_e;

endpackage

// ==== logic/ca_apb_regs.sv ====
// Zero-wait-state APB slave, no pready/pslverr; thresholds keep their value over a soft reset
`timescale 1ns/1ps

module ca_apb_regs
  import ca_types_pkg::*, ca_regs_pkg::*;
(
  input  logic                         com_clk,
  input  logic                         rst,
  input  logic [3:0]                   paddr,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [31:0]                  pwdata,
  output logic [31:0]                  prdata,
  input  align_state_e                 state,       // From the drain FSM
  input  lane_flags_t [NUM_LANES-1:0]  lane_flags,
  output logic                         enable,
  output logic                         soft_reset,  // One-cycle pulse
  output thresh_t                      thresh
);

  logic                 wr_en;       // Access phase of a write
  logic                 rd_en;
  logic [NUM_LANES-1:0] sticky_ovf;  // W1C per lane
  logic [NUM_LANES-1:0] ovf_now;
  logic [31:0]          flags_word;

  assign wr_en = psel & penable & pwrite;
  assign rd_en = psel & ~pwrite;     // Setup and access, prdata only sampled in access

  //////////////////////////////
  // Control register
  //////////////////////////////
  always_ff @(posedge com_clk)
  begin
    if (rst)
    begin
      enable     <= 1'b0;
      soft_reset <= 1'b0;
    end
    else
    begin
      soft_reset <= wr_en && (paddr == ADDR_CTRL) && pwdata[1];  // Self-clearing
      if (soft_reset)
        enable <= 1'b0;                                        // Soft reset drops enable
      else if (wr_en && (paddr == ADDR_CTRL))
        enable <= pwdata[0];
    end
  end

  // Thresholds, only rst restores defaults
  always_ff @(posedge com_clk)
  begin
    if (rst)
      thresh <= THRESH_RST;
    else if (wr_en && (paddr == ADDR_THRESH))
    begin
      thresh.full_val   <= pwdata[5:0];
      thresh.pfull_val  <= pwdata[13:8];
      thresh.empty_val  <= pwdata[18:16];
      thresh.pempty_val <= pwdata[26:24];
    end
  end

  //////////////////////////////
  // Status collection
  //////////////////////////////
  always_comb
  begin
    flags_word = '0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      ovf_now[i]            = lane_flags[i].overflow;
      flags_word[4*i +: 4]  = {lane_flags[i].pempty, lane_flags[i].empty,
                               lane_flags[i].pfull, lane_flags[i].full};  // full lowest
    end
  end

  // New overflow wins over a clear in the same cycle
  always_ff @(posedge com_clk)
  begin
    if (rst || soft_reset)
      sticky_ovf <= '0;
    else if (wr_en && (paddr == ADDR_STATUS))
      sticky_ovf <= (sticky_ovf & ~pwdata[8 +: NUM_LANES]) | ovf_now;
    else
      sticky_ovf <= sticky_ovf | ovf_now;
  end

  // Read mux
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (paddr)
        ADDR_CTRL:
          prdata[0] = enable;          // soft_reset always reads 0
        ADDR_THRESH:
        begin
          prdata[5:0]   = thresh.full_val;
          prdata[13:8]  = thresh.pfull_val;
          prdata[18:16] = thresh.empty_val;
          prdata[26:24] = thresh.pempty_val;
        end
        ADDR_STATUS:
        begin
          prdata[1:0]           = state;
          prdata[8 +: NUM_LANES] = sticky_ovf;
        end
        ADDR_FLAGS:
          prdata = flags_word;
        default:
          prdata = '0;                 // Unmapped
      endcase
    end
  end

endmodule

// ==== logic/ca_rx_marker_detect.sv ====
// Lock is per lane and only taken on a marker word; words before lock are lost, not buffered
`timescale 1ns/1ps

module ca_rx_marker_detect
  import ca_types_pkg::*;
(
  input  logic                        com_clk,
  input  logic                        rst,
  input  logic                        enable,
  input  logic                        soft_reset,
  input  lane_in_t   [NUM_LANES-1:0]  lane_in,
  output logic       [NUM_LANES-1:0]  push,      // Registered, one cycle after lane_in
  output lane_word_t [NUM_LANES-1:0]  wdata
);

  logic [NUM_LANES-1:0] locked;  // Lane has seen its first marker
  logic [NUM_LANES-1:0] take;    // Word goes to the FIFO

  // Accept once locked, or on the marker that takes the lock
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      take[i] = enable & lane_in[i].valid & (locked[i] | lane_in[i].word.marker);
    end
  end

  //////////////////////////////
  // Lock and push
  //////////////////////////////
  always_ff @(posedge com_clk)
  begin
    if (rst || soft_reset || !enable)
    begin
      locked <= '0;   // Disable restarts the hunt
      push   <= '0;
    end
    else
    begin
      locked <= locked | take;
      push   <= take;
    end
  end

  // Word register, loads only on an accepted word
  always_ff @(posedge com_clk)
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (take[i])
        wdata[i] <= lane_in[i].word;
    end
  end

endmodule

// ==== logic/ca_rx_align_fifo.sv ====
// Single-clock FIFO, 16 deep; a push into a full FIFO is dropped even if a pop happens that cycle
`timescale 1ns/1ps

module ca_rx_align_fifo
  import ca_types_pkg::*, ca_regs_pkg::*;
(
  input  logic        com_clk,
  input  logic        rst,
  input  logic        soft_reset,
  input  logic        push,
  input  lane_word_t  wdata,
  input  logic        pop,
  output lane_word_t  rdata,     // Head word, shown ahead
  output logic        empty,     // True empty, not threshold based
  input  thresh_t     thresh,
  output lane_flags_t flags
);

  lane_word_t          mem [FIFO_DEPTH];  // Storage, no reset
  logic [AD_WIDTH-1:0] wr_ptr;
  logic [AD_WIDTH-1:0] rd_ptr;
  logic [CNT_W-1:0]    count;             // 0 to FIFO_DEPTH
  logic                full_int;
  logic                do_push;
  logic                do_pop;
  logic                ovf_q;

  assign full_int = (count == CNT_W'(FIFO_DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push & ~full_int;   // Reject when full
  assign do_pop   = pop & ~empty;       // Underflow ignored
  assign rdata    = mem[rd_ptr];        // Combinational from storage

  //////////////////////////////
  // Storage write
  //////////////////////////////
  always_ff @(posedge com_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= wdata;
  end

  //////////////////////////////
  // Pointers and count
  //////////////////////////////
  always_ff @(posedge com_clk)
  begin
    if (rst || soft_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf_q  <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
      ovf_q <= push & full_int;         // Dropped word
    end
  end

  //////////////////////////////
  // Threshold flags
  //////////////////////////////
  always_comb
  begin
    flags.full     = ({1'b0, count} >= thresh.full_val);
    flags.pfull    = ({1'b0, count} >= thresh.pfull_val);
    flags.empty    = (count == {2'b00, thresh.empty_val});
    flags.pempty   = (count <= {2'b00, thresh.pempty_val});
    flags.overflow = ovf_q;                // Pulse, one cycle after the drop
  end

endmodule

// ==== logic/ca_align_ctrl.sv ====
// Lockstep drain of all lanes; ST_ERROR is left only through soft reset, enable alone does not
`timescale 1ns/1ps

module ca_align_ctrl
  import ca_types_pkg::*, ca_regs_pkg::*;
(
  input  logic                 com_clk,
  input  logic                 rst,
  input  logic                 enable,
  input  logic                 soft_reset,
  input  aligned_beat_t        head,       // Head word of every FIFO
  input  logic [NUM_LANES-1:0] empty,
  input  logic [NUM_LANES-1:0] overflow,
  output logic                 pop,        // Shared by all lanes
  output aligned_beat_t        out_beat,
  output logic                 out_valid,
  input  logic                 out_ready,
  output align_state_e         state
);

  align_state_e state_nxt;
  logic         all_filled;  // No lane empty
  logic         all_marked;  // Marker at every head
  logic         any_ovf;
  logic         out_free;    // Output reg empty or draining

  assign all_filled = ~|empty;
  assign any_ovf    = |overflow;
  assign out_free   = ~out_valid | out_ready;

  always_comb
  begin
    all_marked = 1'b1;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      all_marked = all_marked & head[i].marker;
    end
  end

  //////////////////////////////
  // Next state and pop
  //////////////////////////////
  always_comb
  begin
    state_nxt = state;
    pop       = 1'b0;
    case (state)
      ST_IDLE:
        if (enable)
          state_nxt = ST_HUNT;
      ST_HUNT:
        if (any_ovf)
          state_nxt = ST_ERROR;
        else if (all_filled && all_marked)
        begin
          state_nxt = ST_ALIGNED;
          pop       = out_free;  // Marker beat leaves right away
        end
      ST_ALIGNED:
        if (any_ovf)
          state_nxt = ST_ERROR;   // No pop on the overflow cycle
        else
          pop = all_filled & out_free;
      default:
        state_nxt = ST_ERROR;     // ST_ERROR holds
    endcase
  end

  always_ff @(posedge com_clk)
  begin
    if (rst || soft_reset)
    begin
      state     <= ST_IDLE;
      out_valid <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (pop)
        out_valid <= 1'b1;
      else if (out_ready)
        out_valid <= 1'b0;         // Beat taken
    end
  end

  // Output beat, held until transfer
  always_ff @(posedge com_clk)
  begin
    if (pop)
      out_beat <= head;
  end

endmodule

// ==== logic/ca_rx_align_top.sv ====
// All logic on com_clk, lane clocks already crossed upstream; lane_in has no back-pressure
`timescale 1ns/1ps

module ca_rx_align_top
  import ca_types_pkg::*, ca_regs_pkg::*;
(
  input  logic                      com_clk,
  input  logic                      rst,
  input  logic [3:0]                paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  input  lane_in_t [NUM_LANES-1:0]  lane_in,
  output aligned_beat_t             out_beat,
  output logic                      out_valid,
  input  logic                      out_ready
);

  logic                         enable;
  logic                         soft_reset;
  thresh_t                      thresh;
  align_state_e                 state;
  logic       [NUM_LANES-1:0]   push;
  lane_word_t [NUM_LANES-1:0]   wdata;
  aligned_beat_t                head;        // FIFO heads
  logic       [NUM_LANES-1:0]   fifo_empty;
  lane_flags_t [NUM_LANES-1:0]  lane_flags;
  logic       [NUM_LANES-1:0]   overflow;
  logic                         pop;

  //////////////////////////////
  // Register file
  //////////////////////////////
  ca_apb_regs i_ca_apb_regs
  (
    .com_clk    (com_clk),
    .rst        (rst),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .state      (state),
    .lane_flags (lane_flags),
    .enable     (enable),
    .soft_reset (soft_reset),
    .thresh     (thresh)
  );

  // Marker hunt, feeds every FIFO
  ca_rx_marker_detect i_ca_rx_marker_detect
  (
    .com_clk    (com_clk),
    .rst        (rst),
    .enable     (enable),
    .soft_reset (soft_reset),
    .lane_in    (lane_in),
    .push       (push),
    .wdata      (wdata)
  );

  //////////////////////////////
  // One FIFO per lane
  //////////////////////////////
  for (genvar g = 0; g < NUM_LANES; g++)
  begin : g_lane
    ca_rx_align_fifo i_ca_rx_align_fifo
    (
      .com_clk    (com_clk),
      .rst        (rst),
      .soft_reset (soft_reset),
      .push       (push[g]),
      .wdata      (wdata[g]),
      .pop        (pop),          // Same pop for all lanes
      .rdata      (head[g]),
      .empty      (fifo_empty[g]),
      .thresh     (thresh),
      .flags      (lane_flags[g])
    );

    assign overflow[g] = lane_flags[g].overflow;
  end

  // Drain FSM
  ca_align_ctrl i_ca_align_ctrl
  (
    .com_clk    (com_clk),
    .rst        (rst),
    .enable     (enable),
    .soft_reset (soft_reset),
    .head       (head),
    .empty      (fifo_empty),
    .overflow   (overflow),
    .pop        (pop),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .state      (state)
  );

endmodule

// ==== tb/ca_rx_align_tb.sv ====
// Run from the project root; pattern records are 48 bits wide and the list ends at the first opcode 0
`timescale 1ns/1ps

module ca_rx_align_tb
  import ca_types_pkg::*, ca_regs_pkg::*;
();

  localparam int MAX_RECS    = 64;
  localparam int WDOG_CYCLES = 2000;  // Budget per record

  // Record opcodes
  typedef enum logic [3:0]
  {
    OP_END    = 4'd0,
    OP_WRITE  = 4'd1,
    OP_READ   = 4'd2,
    OP_BURST  = 4'd3,
    OP_STALL  = 4'd4,
    OP_EXPECT = 4'd5
  } op_e;

  typedef struct packed
  {
    op_e         op;
    logic [3:0]  addr;
    logic [31:0] data;   // Write data, read value, lane skews or ready level
    logic [7:0]  count;  // Burst length, stall cycles or beat timeout
  } rec_t;

  logic                      com_clk;
  logic                      rst;
  logic [3:0]                paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  lane_in_t [NUM_LANES-1:0]  lane_in;
  aligned_beat_t             out_beat;
  logic                      out_valid;
  logic                      out_ready;

  logic [47:0]   rec_mem [MAX_RECS];
  aligned_beat_t exp_q [$];  // Beats the DUT still owes
  int            num_recs;
  int            err_count;
  int            check_count;
  integer        seed;

  ca_rx_align_top i_ca_rx_align_top
  (
    .com_clk   (com_clk),
    .rst       (rst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .lane_in   (lane_in),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial
    com_clk = 1'b0;
  always #10 com_clk = ~com_clk;  // 20 ns period

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_beat(input aligned_beat_t exp, input aligned_beat_t act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("[ERROR] %0t out_beat: expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_state(input align_state_e exp, input align_state_e act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("[ERROR] %0t state: expected %s, got %s", $time, exp.name(), act.name());
    end
  endtask

  function automatic string reg_name(input logic [3:0] addr);
    case (addr)
      ADDR_CTRL:   return "CTRL";
      ADDR_THRESH: return "THRESH";
      ADDR_STATUS: return "STATUS";
      ADDR_FLAGS:  return "FLAGS";
      default:     return "UNMAPPED";
    endcase
  endfunction

  //////////////////////////////
  // APB and lane drivers
  //////////////////////////////
  // Entered and left 2 ns after a rising edge
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;      // Setup phase
    @(posedge com_clk);
    #2;
    penable = 1'b1;      // Access phase, write lands on next edge
    @(posedge com_clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge com_clk);
    #2;
    penable = 1'b1;
    @(negedge com_clk);
    data = prdata;       // Mid access phase, stable
    @(posedge com_clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Junk words fill the skew, then marker word and count-1 data words per lane
  task automatic run_burst(input logic [31:0] skews, input int count);
    aligned_beat_t beats [$];
    aligned_beat_t b;
    logic [63:0]   rnd;
    int            sk;
    int            k;
    int            max_skew;
    max_skew = 0;
    for (int j = 0; j < count; j++)
    begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        rnd          = {$random(seed), $random(seed)};
        b[i].marker  = (j == 0);  // Marker opens every lane
        b[i].payload = rnd[38:0];
      end
      beats.push_back(b);
      exp_q.push_back(b);       // Lockstep pops give beat j = word j of each lane
    end
    for (int i = 0; i < NUM_LANES; i++)
    begin
      sk = int'(skews[4*i +: 4]);
      if (sk > max_skew)
        max_skew = sk;
    end
    for (int c = 0; c < max_skew + count; c++)
    begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        sk  = int'(skews[4*i +: 4]);
        k   = c - sk;
        rnd = {$random(seed), $random(seed)};
        lane_in[i].valid = (k < count);
        if (k < 0)
        begin
          lane_in[i].word.marker  = 1'b0;       // Skew filler, must be dropped
          lane_in[i].word.payload = rnd[38:0];
        end
        else if (k < count)
          lane_in[i].word = beats[k][i];
      end
      @(posedge com_clk);
      #2;
    end
    lane_in = '0;
  endtask

  // Waits until every owed beat came out, or the limit runs out
  task automatic wait_beats(input int limit);
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < limit))
    begin
      @(posedge com_clk);
      #2;
      n++;
    end
    if (exp_q.size() != 0)
    begin
      err_count++;
      $display("%0d expected beats did not come out within %0d cycles", exp_q.size(), limit);
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////
  // Negedge sample, transfer happens on the next rising edge
  always @(negedge com_clk)
  begin
    if (!rst && out_valid && out_ready)
    begin
      if (exp_q.size() == 0)
      begin
        err_count++;
        $display("At %0t the DUT sent a beat that was not expected", $time);
      end
      else
        check_beat(exp_q.pop_front(), out_beat);
    end
  end

  // Watchdog, armed once the record count is known
  initial
  begin
    wait (num_recs != 0);
    repeat (num_recs * WDOG_CYCLES) @(posedge com_clk);
    $display("Run did not finish within %0d cycles", num_recs * WDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // Record sequencer
  //////////////////////////////
  initial
  begin
    rec_t        rec;
    logic [31:0] rd;
    int          errs_before;
    rst         = 1'b1;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    lane_in     = '0;
    out_ready   = 1'b1;
    seed        = 20;
    err_count   = 0;
    check_count = 0;
    num_recs    = 0;
    for (int i = 0; i < MAX_RECS; i++)
      rec_mem[i] = '0;  // Unused slots read as end records
    $readmemh("tb/ca_rx_align_patterns.txt", rec_mem);
    while ((num_recs < MAX_RECS) && (rec_mem[num_recs][47:44] != 4'd0))
      num_recs++;
    repeat (2) @(posedge com_clk);  // Two reset cycles
    #2;
    rst = 1'b0;
    for (int r = 0; r < num_recs; r++)
    begin
      rec         = rec_t'(rec_mem[r]);
      errs_before = err_count;
      case (rec.op)
        OP_WRITE:
        begin
          apb_write(rec.addr, rec.data);
          if ((rec.addr == ADDR_CTRL) && rec.data[1])
            exp_q.delete();             // Soft reset flushes FIFOs and output
        end
        OP_READ:
        begin
          apb_read(rec.addr, rd);
          if (rec.addr == ADDR_STATUS)
          begin
            check_state(align_state_e'(rec.data[1:0]), align_state_e'(rd[1:0]));
            check_reg("STATUS", rec.data & ~32'h3, rd & ~32'h3);
          end
          else
            check_reg(reg_name(rec.addr), rec.data, rd);
        end
        OP_BURST:
          run_burst(rec.data, int'(rec.count));
        OP_STALL:
        begin
          out_ready = rec.data[0];
          repeat (rec.count)
          begin
            @(posedge com_clk);
            #2;
          end
        end
        OP_EXPECT:
          wait_beats(int'(rec.count));
        default:
        begin
          err_count++;
          $display("Record %0d holds an unknown opcode", r);
        end
      endcase
      $display("test %0d %s: %s", r, rec.op.name(), (err_count == errs_before) ? "ok" : "mismatch");
    end
    $display("records %0d, checks %0d, errors %0d", num_recs, check_count, err_count);
    if (err_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tb/ca_rx_align_patterns.txt ====
// One record per line: opcode(1) addr(1) data(8) count(2), hex
// 1 write, 2 read-compare, 3 burst (data = lane skews, lane 0 lowest nibble), 4 stall (data[0] = out_ready), 5 expect beats
140300060900
240300060900
2C0000CCCC00
100000000100
200000000100
280000000100
300000153008
5000000000C8
280000000200
100000000000
100000000100
400000000000
30000015300A
40000000000A
2C0000333300
400000000100
5000000000C8
400000000000
300000000014
2800000F0300
100000000200
280000000000
200000000000
400000000100
100000000100
300000153008
5000000000C8
280000000200

// ==== ca_rx_align_top.f ====
logic/ca_types_pkg.sv
logic/ca_regs_pkg.sv
logic/ca_apb_regs.sv
logic/ca_rx_marker_detect.sv
logic/ca_rx_align_fifo.sv
logic/ca_align_ctrl.sv
logic/ca_rx_align_top.sv
tb/ca_rx_align_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status 0 only on a passing run

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=sim_ca_rx_align

verilator --binary --timing --timescale 1ns/1ps \
  -f ca_rx_align_top.f --top-module ca_rx_align_tb -o "$EXE"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
